/* source/sqPkg.sv */
`default_nettype none

package sqPkg;

    // queue geometry
    localparam int NumEntries = 8;
    localparam int IdxLen = 3;
    // index plus one wrap bit so age is a signed difference
    localparam int SqnWidth = 4;

    localparam int DataWidth = 32;
    localparam int MaskWidth = 4;
    localparam int WordAddrWidth = 30;

    typedef logic [SqnWidth-1:0] sqnT;
    typedef logic [IdxLen-1:0] idxT;
    typedef logic [DataWidth-1:0] dataT;
    typedef logic [MaskWidth-1:0] maskT;
    typedef logic [WordAddrWidth-1:0] wordAddrT;

    typedef enum logic [1:0] {
        sizeByte = 2'd0,
        sizeHalf = 2'd1,
        sizeWord = 2'd2
    } accessSizeT;

    typedef enum logic [0:0] {
        flushIdle = 1'b0,
        flushDrain = 1'b1
    } flushStateT;

    typedef struct packed {
        logic valid;
        sqnT storeSqn;
    } allocReqT;

    typedef struct packed {
        logic valid;
        sqnT storeSqn;
        wordAddrT addr;
        maskT wmask;
    } addrReqT;

    typedef struct packed {
        logic valid;
        sqnT storeSqn;
        dataT data;
    } dataReqT;

    typedef struct packed {
        logic taken;
        logic flush;
        sqnT storeSqn;
    } branchT;

    // storeSqn is the first store younger than the load
    typedef struct packed {
        logic valid;
        logic [31:0] addr;
        accessSizeT size;
        sqnT storeSqn;
    } loadReqT;

    typedef struct packed {
        logic valid;
        dataT data;
        maskT mask;
        logic conflict;
    } fwdResultT;

    typedef struct packed {
        dataT data;
        wordAddrT addr;
        maskT wmask;
        sqnT storeSqn;
        logic addrAvail;
        logic loaded;
    } sqEntryT;

    typedef struct packed {
        logic valid;
        wordAddrT addr;
        dataT data;
        maskT wmask;
    } storeOutT;

endpackage

`default_nettype wire

/* source/sqPointers.sv */
`default_nettype none

module sqPointers (
    input wire clk,
    input wire rst,
    input wire sqPkg::allocReqT alloc,
    input wire sqPkg::branchT branch,
    input wire sqPkg::sqnT comStSqn,
    input wire deq,
    output logic [sqPkg::NumEntries-1:0] entryValid,
    output logic [sqPkg::NumEntries-1:0] entryReady,
    output sqPkg::sqnT baseIdx,
    output logic queueEmpty,
    output sqPkg::sqnT maxStoreSqn,
    output logic done
);

    // tail points at the youngest allocated store
    sqPkg::sqnT lastIdx;
    sqPkg::idxT baseI;
    sqPkg::idxT lastI;
    sqPkg::idxT comI;
    logic queueFull;
    logic allCommitted;
    sqPkg::sqnT allocAhead;

    assign baseI = baseIdx[sqPkg::IdxLen-1:0];
    assign lastI = lastIdx[sqPkg::IdxLen-1:0];
    assign comI = comStSqn[sqPkg::IdxLen-1:0];

    // same index but a full lap apart
    assign queueFull = (baseIdx + sqPkg::sqnT'(sqPkg::NumEntries - 1)) == lastIdx;
    assign allCommitted = (baseIdx + sqPkg::sqnT'(sqPkg::NumEntries)) == comStSqn;

    always_ff @(posedge clk) begin
        if (rst) begin
            baseIdx <= '0;
            lastIdx <= '1;
        end else begin
            if (deq)
                baseIdx <= baseIdx + 1'b1;
            // rollback wins over rename
            if (branch.taken)
                lastIdx <= branch.storeSqn;
            else if (alloc.valid)
                lastIdx <= alloc.storeSqn;
        end
    end

    // walk the ring, turning on at head and off past the committed pointer
    always_comb begin
        logic active;
        active = comI < baseI;
        for (int i = 0; i < sqPkg::NumEntries; i++) begin
            if (allCommitted)
                active = 1'b1;
            else if (sqPkg::idxT'(i) == comI)
                active = 1'b0;
            else if (sqPkg::idxT'(i) == baseI)
                active = 1'b1;
            entryReady[i] = active;
        end
    end

    always_comb begin
        sqPkg::idxT lastNext;
        logic active;
        lastNext = lastI + 1'b1;
        active = lastNext < baseI;
        for (int i = 0; i < sqPkg::NumEntries; i++) begin
            if (queueFull)
                active = 1'b1;
            else if (sqPkg::idxT'(i - 1) == lastI)
                active = 1'b0;
            else if (sqPkg::idxT'(i) == baseI)
                active = 1'b1;
            entryValid[i] = active;
        end
    end

    assign queueEmpty = ~|entryValid;
    assign maxStoreSqn = baseIdx + sqPkg::sqnT'(sqPkg::NumEntries - 1);
    assign done = baseIdx == comStSqn;

    assign allocAhead = alloc.storeSqn - maxStoreSqn;

    // rename must not run past the free slots
    allocInRange: assert property (@(posedge clk) disable iff (rst)
        alloc.valid && !branch.taken |-> $signed(allocAhead) <= 0)
        else $error("store allocation beyond maxStoreSqn");

endmodule

`default_nettype wire

/* source/sqFlushFsm.sv */
`default_nettype none

module sqFlushFsm (
    input wire clk,
    input wire rst,
    input wire sqPkg::branchT branch,
    input wire queueEmpty,
    input wire allocStrobe,
    input wire addrStrobe,
    output logic flush,
    output logic empty
);

    sqPkg::flushStateT state;
    sqPkg::flushStateT stateNext;
    logic emptyQ;

    always_comb begin
        stateNext = state;
        case (state)
            sqPkg::flushIdle:
                if (branch.taken && branch.flush)
                    stateNext = sqPkg::flushDrain;
            sqPkg::flushDrain:
                if (emptyQ)
                    stateNext = sqPkg::flushIdle;
            default:
                stateNext = sqPkg::flushIdle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= sqPkg::flushIdle;
            emptyQ <= 1'b1;
        end else begin
            state <= stateNext;
            // any write this cycle means the queue is still busy
            emptyQ <= queueEmpty && !allocStrobe && !addrStrobe;
        end
    end

    assign flush = state == sqPkg::flushDrain;
    assign empty = emptyQ;

endmodule

`default_nettype wire

/* source/sqEntryArray.sv */
`default_nettype none

module sqEntryArray (
    input wire clk,
    input wire rst,
    input wire sqPkg::allocReqT alloc,
    input wire sqPkg::addrReqT addrIn,
    input wire sqPkg::dataReqT dataIn,
    input wire sqPkg::branchT branch,
    input wire [sqPkg::NumEntries-1:0] entryValid,
    output sqPkg::sqEntryT [sqPkg::NumEntries-1:0] entries
);

    sqPkg::idxT allocIdx;
    sqPkg::idxT addrIdx;
    sqPkg::idxT dataIdx;
    sqPkg::sqnT addrAge;
    sqPkg::sqnT dataAge;
    logic addrKeep;
    logic dataKeep;

    assign allocIdx = alloc.storeSqn[sqPkg::IdxLen-1:0];
    assign addrIdx = addrIn.storeSqn[sqPkg::IdxLen-1:0];
    assign dataIdx = dataIn.storeSqn[sqPkg::IdxLen-1:0];

    // age relative to the branch where positive means younger
    assign addrAge = addrIn.storeSqn - branch.storeSqn;
    assign dataAge = dataIn.storeSqn - branch.storeSqn;

    assign addrKeep = addrIn.valid &&
        (!branch.taken || (!branch.flush && $signed(addrAge) <= 0));
    assign dataKeep = dataIn.valid &&
        (!branch.taken || (!branch.flush && $signed(dataAge) <= 0));

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < sqPkg::NumEntries; i++) begin
                entries[i].addrAvail <= 1'b0;
                entries[i].loaded <= 1'b0;
            end
        end else begin
            if (dataKeep) begin
                entries[dataIdx].data <= dataIn.data;
                entries[dataIdx].loaded <= 1'b1;
            end
            if (addrKeep) begin
                entries[addrIdx].addr <= addrIn.addr;
                entries[addrIdx].wmask <= addrIn.wmask;
                entries[addrIdx].addrAvail <= 1'b1;
            end
            // a fresh slot forgets whatever the last store left there
            if (alloc.valid) begin
                entries[allocIdx].storeSqn <= alloc.storeSqn;
                entries[allocIdx].wmask <= '0;
                entries[allocIdx].addrAvail <= 1'b0;
                entries[allocIdx].loaded <= 1'b0;
            end
        end
    end

    // address unit only targets live stores, and only once each
    addrOnFreshEntry: assert property (@(posedge clk) disable iff (rst)
        addrKeep |-> entryValid[addrIdx] && !entries[addrIdx].addrAvail)
        else $error("address write to an invalid or already addressed entry");

endmodule

`default_nettype wire

/* source/sqForward.sv */
`default_nettype none

module sqForward (
    input wire clk,
    input wire rst,
    input wire sqPkg::loadReqT load,
    input wire sqPkg::sqEntryT [sqPkg::NumEntries-1:0] entries,
    input wire [sqPkg::NumEntries-1:0] entryValid,
    input wire [sqPkg::NumEntries-1:0] entryReady,
    input wire sqPkg::sqnT baseIdx,
    input wire sqPkg::storeOutT storeOut,
    output sqPkg::fwdResultT fwd
);

    sqPkg::wordAddrT loadWordAddr;
    sqPkg::maskT readMask;
    sqPkg::dataT lookupData;
    sqPkg::maskT lookupMask;
    logic lookupConflict;

    assign loadWordAddr = load.addr[31:2];

    // bytes touched by the load
    always_comb begin
        case (load.size)
            sqPkg::sizeByte:
                readMask = sqPkg::maskT'(1) << load.addr[1:0];
            sqPkg::sizeHalf:
                readMask = load.addr[1] ? 4'b1100 : 4'b0011;
            default:
                readMask = 4'b1111;
        endcase
    end

    always_comb begin
        sqPkg::idxT idx;
        sqPkg::sqnT ageDiff;
        logic match;
        // unread bytes count as already available
        lookupMask = ~readMask;
        lookupData = '0;
        lookupConflict = 1'b0;

        // drain register is older than anything still in the queue
        if (storeOut.valid && storeOut.addr == loadWordAddr) begin
            for (int j = 0; j < sqPkg::MaskWidth; j++)
                if (storeOut.wmask[j])
                    lookupData[j*8 +: 8] = storeOut.data[j*8 +: 8];
            lookupMask = lookupMask | storeOut.wmask;
        end

        // start at head so younger stores overwrite older bytes
        for (int k = 0; k < sqPkg::NumEntries; k++) begin
            idx = baseIdx[sqPkg::IdxLen-1:0] + sqPkg::idxT'(k);
            ageDiff = entries[idx].storeSqn - load.storeSqn;
            match = entryValid[idx] && entries[idx].addrAvail &&
                entries[idx].addr == loadWordAddr &&
                (entryReady[idx] || $signed(ageDiff) < 0);
            if (match) begin
                if (entries[idx].loaded) begin
                    for (int j = 0; j < sqPkg::MaskWidth; j++)
                        if (entries[idx].wmask[j]) begin
                            lookupData[j*8 +: 8] = entries[idx].data[j*8 +: 8];
                            lookupMask[j] = 1'b1;
                        end
                end else if ((entries[idx].wmask & readMask) != '0) begin
                    // address known but data still in flight
                    lookupConflict = 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load.valid) begin
            fwd.data <= lookupData;
            fwd.mask <= lookupMask;
            fwd.conflict <= lookupConflict;
        end
        if (rst)
            fwd.valid <= 1'b0;
        else
            fwd.valid <= load.valid;
    end

endmodule

`default_nettype wire

/* source/sqDrain.sv */
`default_nettype none

module sqDrain (
    input wire clk,
    input wire rst,
    input wire sqPkg::sqEntryT [sqPkg::NumEntries-1:0] entries,
    input wire [sqPkg::NumEntries-1:0] entryReady,
    input wire sqPkg::sqnT baseIdx,
    input wire stall,
    output sqPkg::storeOutT storeOut,
    output logic deq
);

    sqPkg::idxT headIdx;
    sqPkg::sqEntryT head;
    logic headReady;
    logic canLoad;

    assign headIdx = baseIdx[sqPkg::IdxLen-1:0];
    assign head = entries[headIdx];
    assign headReady = entryReady[headIdx];

    // register is free or memory takes its content this cycle
    assign canLoad = !storeOut.valid || !stall;
    assign deq = canLoad && headReady;

    always_ff @(posedge clk) begin
        if (deq) begin
            storeOut.addr <= head.addr;
            storeOut.data <= head.data;
            storeOut.wmask <= head.wmask;
        end
        if (rst)
            storeOut.valid <= 1'b0;
        else if (canLoad)
            storeOut.valid <= headReady;
    end

    // a store leaves only once its address and data are in
    headComplete: assert property (@(posedge clk) disable iff (rst)
        deq |-> head.addrAvail && head.loaded)
        else $error("store drained before its address and data arrived");

endmodule

`default_nettype wire

/* source/storeQueue.sv */
`default_nettype none

module storeQueue (
    input wire clk,
    input wire rst,
    input wire sqPkg::allocReqT alloc,
    input wire sqPkg::addrReqT addrIn,
    input wire sqPkg::dataReqT dataIn,
    input wire sqPkg::branchT branch,
    input wire sqPkg::sqnT comStSqn,
    input wire sqPkg::loadReqT load,
    input wire stall,
    output sqPkg::fwdResultT fwd,
    output sqPkg::storeOutT storeOut,
    output logic empty,
    output logic done,
    output logic flush,
    output sqPkg::sqnT maxStoreSqn
);

    logic [sqPkg::NumEntries-1:0] entryValid;
    logic [sqPkg::NumEntries-1:0] entryReady;
    sqPkg::sqnT baseIdx;
    logic queueEmpty;
    logic deq;
    sqPkg::sqEntryT [sqPkg::NumEntries-1:0] entries;

    sqPointers pointers (
        .clk(clk),
        .rst(rst),
        .alloc(alloc),
        .branch(branch),
        .comStSqn(comStSqn),
        .deq(deq),
        .entryValid(entryValid),
        .entryReady(entryReady),
        .baseIdx(baseIdx),
        .queueEmpty(queueEmpty),
        .maxStoreSqn(maxStoreSqn),
        .done(done)
    );

    sqFlushFsm flushFsm (
        .clk(clk),
        .rst(rst),
        .branch(branch),
        .queueEmpty(queueEmpty),
        .allocStrobe(alloc.valid),
        .addrStrobe(addrIn.valid),
        .flush(flush),
        .empty(empty)
    );

    sqEntryArray entryArray (
        .clk(clk),
        .rst(rst),
        .alloc(alloc),
        .addrIn(addrIn),
        .dataIn(dataIn),
        .branch(branch),
        .entryValid(entryValid),
        .entries(entries)
    );

    // lookup also sees the store held in the drain register
    sqForward forward (
        .clk(clk),
        .rst(rst),
        .load(load),
        .entries(entries),
        .entryValid(entryValid),
        .entryReady(entryReady),
        .baseIdx(baseIdx),
        .storeOut(storeOut),
        .fwd(fwd)
    );

    sqDrain drain (
        .clk(clk),
        .rst(rst),
        .entries(entries),
        .entryReady(entryReady),
        .baseIdx(baseIdx),
        .stall(stall),
        .storeOut(storeOut),
        .deq(deq)
    );

endmodule

`default_nettype wire

/* testbench/tbStoreQueue.sv */
`default_nettype none

module tbStoreQueue;
    timeunit 1ns;
    timeprecision 1ps;

    logic clk;
    logic rst;
    sqPkg::allocReqT alloc;
    sqPkg::addrReqT addrIn;
    sqPkg::dataReqT dataIn;
    sqPkg::branchT branch;
    sqPkg::sqnT comStSqn;
    sqPkg::loadReqT load;
    logic stall;
    sqPkg::fwdResultT fwd;
    sqPkg::storeOutT storeOut;
    logic empty;
    logic done;
    logic flush;
    sqPkg::sqnT maxStoreSqn;

    int mismatches;
    int failures;
    int fd;
    int code;
    // command word from the case file sits in the low bytes
    logic [8*16-1:0] cmd;
    logic [31:0] field [6];

    storeQueue dut (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic checkValue(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
        if (actual !== expected) begin
            $display("MISMATCH %s at %0t: got %h, expected %h", name, $time, actual, expected);
            mismatches++;
        end
    endtask

    // pull the hex fields that follow a command word
    task automatic readFields(input int count);
        for (int i = 0; i < count; i++) begin
            code = $fscanf(fd, "%h", field[i]);
            if (code != 1) begin
                $display("case file line for %0s is missing a hexadecimal field", cmd);
                failures++;
            end
        end
    endtask

    // one clock with the current strobes before they drop
    task automatic step();
        @(negedge clk);
        alloc = '0;
        addrIn = '0;
        dataIn = '0;
        branch = '0;
        load = '0;
    endtask

    task automatic waitStoreOut();
        int n;
        n = 0;
        while (!storeOut.valid && n < 100) begin
            @(negedge clk);
            n++;
        end
        if (!storeOut.valid) begin
            $display("timeout: no store appeared at the memory port within 100 cycles");
            failures++;
        end
    endtask

    task automatic waitFlushLow();
        int n;
        n = 0;
        while (flush && n < 100) begin
            @(negedge clk);
            n++;
        end
        if (flush) begin
            $display("timeout: flush was still high after 100 cycles");
            failures++;
        end
    endtask

    task automatic applyCommand();
        case (cmd)
            "#": begin
                code = $fgetc(fd);
                while (code != "\n" && code != -1)
                    code = $fgetc(fd);
            end
            "alloc": begin
                readFields(1);
                alloc.valid = 1'b1;
                alloc.storeSqn = sqPkg::sqnT'(field[0]);
                step();
            end
            "addr": begin
                readFields(3);
                addrIn.valid = 1'b1;
                addrIn.storeSqn = sqPkg::sqnT'(field[0]);
                addrIn.addr = sqPkg::wordAddrT'(field[1]);
                addrIn.wmask = sqPkg::maskT'(field[2]);
                step();
            end
            "data": begin
                readFields(2);
                dataIn.valid = 1'b1;
                dataIn.storeSqn = sqPkg::sqnT'(field[0]);
                dataIn.data = field[1];
                step();
            end
            "commit": begin
                readFields(1);
                comStSqn = sqPkg::sqnT'(field[0]);
                step();
            end
            "load": begin
                readFields(3);
                load.valid = 1'b1;
                load.addr = field[0];
                load.size = sqPkg::accessSizeT'(field[1][1:0]);
                load.storeSqn = sqPkg::sqnT'(field[2]);
                step();
            end
            "branch": begin
                readFields(6);
                branch.taken = 1'b1;
                branch.flush = field[0][0];
                branch.storeSqn = sqPkg::sqnT'(field[1]);
                // address and data writes that race the branch
                addrIn.valid = 1'b1;
                addrIn.storeSqn = sqPkg::sqnT'(field[2]);
                addrIn.addr = sqPkg::wordAddrT'(field[3]);
                addrIn.wmask = sqPkg::maskT'(field[4]);
                dataIn.valid = 1'b1;
                dataIn.storeSqn = sqPkg::sqnT'(field[2]);
                dataIn.data = field[5];
                step();
            end
            "stall": begin
                readFields(1);
                stall = field[0][0];
                step();
            end
            "idle": begin
                readFields(1);
                for (int i = 0; i < field[0]; i++)
                    step();
            end
            "expFwd": begin
                readFields(3);
                checkValue("fwd.valid", fwd.valid, 1);
                checkValue("fwd.data", fwd.data, field[0]);
                checkValue("fwd.mask", fwd.mask, field[1]);
                checkValue("fwd.conflict", fwd.conflict, field[2]);
            end
            "expOut": begin
                readFields(3);
                waitStoreOut();
                if (storeOut.valid) begin
                    checkValue("storeOut.addr", storeOut.addr, field[0]);
                    checkValue("storeOut.data", storeOut.data, field[1]);
                    checkValue("storeOut.wmask", storeOut.wmask, field[2]);
                    // memory takes it on the next edge unless stalled
                    if (!stall)
                        step();
                end
            end
            "expFlag": begin
                readFields(4);
                checkValue("empty", empty, field[0]);
                checkValue("flush", flush, field[1]);
                checkValue("done", done, field[2]);
                checkValue("maxStoreSqn", maxStoreSqn, field[3]);
            end
            "waitFlush": waitFlushLow();
            default: begin
                $display("unknown command %0s in the case file", cmd);
                failures++;
            end
        endcase
    endtask

    initial begin
        rst = 1'b1;
        alloc = '0;
        addrIn = '0;
        dataIn = '0;
        branch = '0;
        comStSqn = '0;
        load = '0;
        stall = 1'b0;
        mismatches = 0;
        failures = 0;
        fd = $fopen("testbench/sqCases.txt", "r");
        if (fd == 0) begin
            $display("could not open testbench/sqCases.txt");
            failures++;
        end
        // two rising edges under reset, released on a falling edge
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        checkValue("storeOut.valid", storeOut.valid, 0);
        checkValue("fwd.valid", fwd.valid, 0);
        while (fd != 0 && failures == 0 && $fscanf(fd, "%s", cmd) == 1)
            applyCommand();
        if (fd != 0)
            $fclose(fd);
        $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
        if (mismatches == 0 && failures == 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

endmodule

`default_nettype wire

/* storeQueue.f */
source/sqPkg.sv
source/sqPointers.sv
source/sqFlushFsm.sv
source/sqEntryArray.sv
source/sqForward.sv
source/sqDrain.sv
source/storeQueue.sv
testbench/tbStoreQueue.sv

/* Bender.yml */
package:
  name: storeQueue

sources:
  - source/sqPkg.sv
  - source/sqPointers.sv
  - source/sqFlushFsm.sv
  - source/sqEntryArray.sv
  - source/sqForward.sv
  - source/sqDrain.sv
  - source/storeQueue.sv
  - target: test
    files:
      - testbench/tbStoreQueue.sv

/* testbench/sqCases.txt */
# alloc sqn | addr sqn wordAddr wmask | data sqn word | commit sqn | load byteAddr size sqn
# branch flush sqn wrSqn wrAddr wrMask wrData | stall lvl | idle n | waitFlush
# expFwd data mask conflict | expOut wordAddr data wmask | expFlag empty flush done maxSqn
expFlag 1 0 1 7
alloc 0
alloc 1
alloc 2
addr 0 100 f
data 0 11223344
addr 1 100 6
data 1 aabbccdd
# forwarding and age
load 400 2 2
expFwd 11bbcc44 f 0
load 402 0 0
expFwd 00000000 b 0
# conflict
addr 2 100 8
load 400 2 3
expFwd 11bbcc44 f 1
load 400 0 3
expFwd 11bbcc44 f 0
data 2 55667788
# draining
commit 2
expOut 100 11223344 f
expOut 100 aabbccdd 6
expFlag 0 0 1 9
# stall
alloc 3
addr 3 200 f
data 3 cafef00d
stall 1
commit 4
expOut 100 55667788 8
idle 3
expOut 100 55667788 8
load 400 2 4
expFwd 55000000 8 0
expFlag 0 0 0 a
stall 0
expOut 200 cafef00d f
expFlag 1 0 1 b
# flushing branch
alloc 4
alloc 5
alloc 6
addr 4 300 f
data 4 01020304
addr 5 300 c
data 5 a0b0c0d0
branch 1 5 6 300 f deadbeef
expFlag 0 1 1 b
load c00 2 7
expFwd a0b00304 f 0
commit 6
expOut 300 01020304 f
expOut 300 a0b0c0d0 c
waitFlush
expFlag 1 0 1 d
